//--- hdl/fetch_pkg.sv
package fetch_pkg;

   localparam int ADDR_W       = 32;
   localparam int LG_CL_BYTES  = 4;
   localparam int WORDS_PER_CL = 4;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [31:0]       insn_word_t;

   // word 0 sits in the low 32 bits
   typedef insn_word_t [WORDS_PER_CL-1:0] cache_line_t;

   // control-flow class, filled in at refill time
   typedef enum logic [3:0]
   {
      NOT_CFLOW      = 4'd0,
      IS_COND_BR     = 4'd1,
      IS_L_COND_BR   = 4'd2,
      IS_J           = 4'd3,
      IS_JAL         = 4'd4,
      IS_JR          = 4'd5,
      IS_JALR        = 4'd6,
      IS_BR          = 4'd7,
      IS_BR_AND_LINK = 4'd8
   } jump_t;

   typedef enum logic [2:0]
   {
      IDLE              = 3'd0,
      ACTIVE            = 3'd1,
      INJECT_RELOAD     = 3'd2,
      RELOAD_TURNAROUND = 3'd3,
      FLUSH_CACHE       = 3'd4,
      WAIT_FOR_NOT_FULL = 3'd5
   } fetch_state_t;

   typedef struct packed
   {
      insn_word_t data;
      addr_t      pc;
      addr_t      pred_target; // next pc the front end followed
      logic       pred;
   } fetch_entry_t;

endpackage

//--- hdl/icache_refill.sv
`timescale 1ns/1ps

module icache_refill
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   miss_valid,
   input  fetch_pkg::addr_t       miss_pc,
   output logic                   mem_req_valid,
   output fetch_pkg::addr_t       mem_req_addr,
   input  logic                   mem_rsp_valid,
   input  fetch_pkg::cache_line_t mem_rsp_load_data,
   output logic                   fill_valid,
   output fetch_pkg::addr_t       fill_addr,
   output fetch_pkg::cache_line_t fill_words
);

   logic             r_req_valid;
   fetch_pkg::addr_t r_line_addr; // line being refilled

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_req_valid <= 1'b0;
      end
      else
      begin
         r_req_valid <= miss_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (miss_valid)
      begin
         r_line_addr <= {miss_pc[fetch_pkg::ADDR_W-1:fetch_pkg::LG_CL_BYTES],
                         {fetch_pkg::LG_CL_BYTES{1'b0}}};
      end
   end

   assign mem_req_valid = r_req_valid;
   assign mem_req_addr  = r_line_addr;
   assign fill_valid    = mem_rsp_valid;
   assign fill_addr     = r_line_addr;

   // memory hands back big-endian words
   always_comb
   begin
      for (int i = 0; i < fetch_pkg::WORDS_PER_CL; i++)
      begin
         fill_words[i] = {mem_rsp_load_data[i][7:0],   mem_rsp_load_data[i][15:8],
                          mem_rsp_load_data[i][23:16], mem_rsp_load_data[i][31:24]};
      end
   end

endmodule

//--- hdl/insn_predecode.sv
`timescale 1ns/1ps

module insn_predecode
(
   input  fetch_pkg::insn_word_t word,
   output fetch_pkg::jump_t      cls
);

   logic [5:0] opcode;
   logic [4:0] rs;
   logic [4:0] rt;
   logic [5:0] funct;

   assign opcode = word[31:26];
   assign rs     = word[25:21];
   assign rt     = word[20:16];
   assign funct  = word[5:0];

   always_comb
   begin
      cls = fetch_pkg::NOT_CFLOW;
      case (opcode)
         6'd0: // special
         begin
            if (funct == 6'd8)
               cls = fetch_pkg::IS_JR;
            else if (funct == 6'd9)
               cls = fetch_pkg::IS_JALR;
         end
         6'd1: // regimm, decoded on rt
         begin
            case (rt)
               5'd0, 5'd1: cls = fetch_pkg::IS_COND_BR;
               5'd2, 5'd3: cls = fetch_pkg::IS_L_COND_BR;
               5'd17:      cls = fetch_pkg::IS_BR_AND_LINK; // bgezal, bal when rs is 0
               default:    cls = fetch_pkg::NOT_CFLOW;
            endcase
         end
         6'd2: cls = fetch_pkg::IS_J;
         6'd3: cls = fetch_pkg::IS_JAL;
         6'd4: // beq r0,r0 always goes
         begin
            cls = (rs == 5'd0 && rt == 5'd0) ? fetch_pkg::IS_BR : fetch_pkg::IS_COND_BR;
         end
         6'd5, 6'd6, 6'd7: cls = fetch_pkg::IS_COND_BR; // bne blez bgtz
         6'd17: // cop1 branches
         begin
            if (rs == 5'd8)
            begin
               cls = word[17] ? fetch_pkg::IS_L_COND_BR : fetch_pkg::IS_COND_BR;
            end
         end
         6'd20, 6'd21, 6'd22, 6'd23: cls = fetch_pkg::IS_L_COND_BR; // likely forms
         default: cls = fetch_pkg::NOT_CFLOW;
      endcase
   end

endmodule

//--- hdl/icache_arrays.sv
`timescale 1ns/1ps

module icache_arrays
#(
   parameter int LG_NUM_SETS = 6
)
(
   input  logic                                               clk,
   input  logic                                               reset,
   input  logic                                               rd_en,
   input  fetch_pkg::addr_t                                   rd_pc,
   output logic                                               hit,
   output fetch_pkg::insn_word_t                              rd_word,
   output fetch_pkg::jump_t                                   rd_class,
   input  logic                                               fill_valid,
   input  fetch_pkg::addr_t                                   fill_addr,
   input  fetch_pkg::cache_line_t                             fill_words,
   input  fetch_pkg::jump_t [fetch_pkg::WORDS_PER_CL-1:0]     fill_class,
   input  logic                                               flush_start,
   output logic                                               flush_done
);

   localparam int NUM_SETS = 1 << LG_NUM_SETS;
   localparam int IDX_LO   = fetch_pkg::LG_CL_BYTES;
   localparam int IDX_HI   = fetch_pkg::LG_CL_BYTES + LG_NUM_SETS;
   localparam int TAG_W    = fetch_pkg::ADDR_W - IDX_HI;

   typedef logic [TAG_W-1:0]       tag_t;
   typedef logic [LG_NUM_SETS-1:0] set_idx_t;

   logic [NUM_SETS-1:0]    r_valid;
   tag_t                   r_tag [NUM_SETS];
   fetch_pkg::cache_line_t r_line [NUM_SETS];
   fetch_pkg::jump_t [fetch_pkg::WORDS_PER_CL-1:0] r_class [NUM_SETS];

   logic                   r_rd_en;
   fetch_pkg::addr_t       r_rd_pc;
   logic                   r_valid_out;
   tag_t                   r_tag_out;
   fetch_pkg::cache_line_t r_line_out;
   fetch_pkg::jump_t [fetch_pkg::WORDS_PER_CL-1:0] r_class_out;

   logic     r_flushing;
   set_idx_t r_flush_idx;
   set_idx_t rd_idx;
   set_idx_t fill_idx;

   assign rd_idx   = rd_pc[IDX_HI-1:IDX_LO];
   assign fill_idx = fill_addr[IDX_HI-1:IDX_LO];

   always_ff @(posedge clk)
   begin
      r_valid_out <= r_valid[rd_idx];
      r_tag_out   <= r_tag[rd_idx];
      r_line_out  <= r_line[rd_idx];
      r_class_out <= r_class[rd_idx];
      r_rd_pc     <= rd_pc;
      if (fill_valid)
      begin
         r_tag[fill_idx]   <= fill_addr[fetch_pkg::ADDR_W-1:IDX_HI];
         r_line[fill_idx]  <= fill_words;
         r_class[fill_idx] <= fill_class;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid     <= '0;
         r_rd_en     <= 1'b0;
         r_flushing  <= 1'b0;
         r_flush_idx <= '0;
      end
      else
      begin
         r_rd_en <= rd_en;
         if (r_flushing)
         begin
            r_valid[r_flush_idx] <= 1'b0;
            r_flush_idx          <= r_flush_idx + 1'b1; // wraps to 0 after last set
            if (flush_done)
               r_flushing <= 1'b0;
         end
         else if (fill_valid)
         begin
            r_valid[fill_idx] <= 1'b1;
         end
         if (flush_start)
         begin
            r_flushing  <= 1'b1;
            r_flush_idx <= '0;
         end
      end
   end

   assign flush_done = r_flushing && (r_flush_idx == set_idx_t'(NUM_SETS - 1));
   assign hit        = r_rd_en && r_valid_out &&
                       (r_tag_out == r_rd_pc[fetch_pkg::ADDR_W-1:IDX_HI]);
   assign rd_word    = r_line_out[r_rd_pc[IDX_LO-1:2]];
   assign rd_class   = r_class_out[r_rd_pc[IDX_LO-1:2]];

endmodule

//--- hdl/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    restart_valid,
   input  fetch_pkg::addr_t        restart_pc,
   output logic                    restart_ack,
   input  logic                    flush_req,
   output logic                    flush_complete,
   output logic                    rd_en,
   output fetch_pkg::addr_t        rd_pc,
   input  logic                    hit,
   input  fetch_pkg::insn_word_t   rd_word,
   input  fetch_pkg::jump_t        rd_class,
   output logic                    miss_valid,
   output fetch_pkg::addr_t        miss_pc,
   input  logic                    fill_valid,
   output logic                    flush_start,
   input  logic                    flush_done,
   input  logic                    full,
   output logic                    push,
   output fetch_pkg::fetch_entry_t push_entry,
   output logic                    clear
);

   fetch_pkg::fetch_state_t r_state, n_state;
   fetch_pkg::addr_t r_pc, n_pc;             // next pc to read
   fetch_pkg::addr_t r_cache_pc, n_cache_pc; // pc of the read in flight
   fetch_pkg::addr_t r_miss_pc, n_miss_pc;
   fetch_pkg::addr_t r_restart_pc, t_restart_pc;
   fetch_pkg::addr_t t_target, t_simm_sh;
   logic r_req, n_req;
   logic r_delay_slot, n_delay_slot;
   logic r_restart_req, n_restart_req;
   logic r_flush_req, n_flush_req;
   logic r_restart_ack, n_restart_ack;
   logic r_flush_complete, n_flush_complete;
   logic t_take;

   // static target and direction of the word that just came back
   always_comb
   begin
      t_simm_sh = {{14{rd_word[15]}}, rd_word[15:0], 2'b00};
      t_target  = r_cache_pc + 32'd4 + t_simm_sh;
      if (rd_class == fetch_pkg::IS_J || rd_class == fetch_pkg::IS_JAL)
         t_target = {r_cache_pc[31:28], rd_word[25:0], 2'b00};
      t_take = !r_delay_slot &&
               (rd_class == fetch_pkg::IS_J || rd_class == fetch_pkg::IS_JAL ||
                rd_class == fetch_pkg::IS_BR || rd_class == fetch_pkg::IS_L_COND_BR ||
                (rd_class == fetch_pkg::IS_BR_AND_LINK && rd_word[25:21] == 5'd0));
      push_entry.data        = rd_word;
      push_entry.pc          = r_cache_pc;
      push_entry.pred        = t_take;
      push_entry.pred_target = t_take ? t_target : r_pc; // r_pc is the target after a slot
   end

   always_comb
   begin
      n_state          = r_state;
      n_pc             = r_pc;
      n_cache_pc       = r_cache_pc;
      n_miss_pc        = r_miss_pc;
      n_req            = 1'b0;
      n_delay_slot     = r_delay_slot;
      n_restart_req    = r_restart_req | restart_valid;
      n_flush_req      = r_flush_req | flush_req;
      n_restart_ack    = 1'b0;
      n_flush_complete = 1'b0;
      t_restart_pc     = restart_valid ? restart_pc : r_restart_pc;
      miss_valid       = 1'b0;
      flush_start      = 1'b0;
      push             = 1'b0;
      clear            = 1'b0;
      if (r_state == fetch_pkg::ACTIVE)
      begin
         n_cache_pc = r_pc; // keep streaming
         n_req      = 1'b1;
         n_pc       = r_pc + 32'd4;
      end
      case (r_state)
         fetch_pkg::IDLE, fetch_pkg::ACTIVE, fetch_pkg::RELOAD_TURNAROUND,
         fetch_pkg::WAIT_FOR_NOT_FULL:
         begin
            if (n_flush_req)
            begin
               n_flush_req  = 1'b0;
               n_req        = 1'b0;
               n_delay_slot = 1'b0;
               flush_start  = 1'b1;
               clear        = 1'b1;
               n_state      = fetch_pkg::FLUSH_CACHE;
            end
            else if (n_restart_req)
            begin
               n_restart_req = 1'b0;
               n_restart_ack = 1'b1;
               n_req         = 1'b0;
               n_delay_slot  = 1'b0;
               n_pc          = t_restart_pc;
               clear         = 1'b1;
               n_state       = fetch_pkg::ACTIVE;
            end
            else if (r_state == fetch_pkg::RELOAD_TURNAROUND ||
                     (r_state == fetch_pkg::WAIT_FOR_NOT_FULL && !full))
            begin
               n_cache_pc = r_miss_pc; // re-read the line that stalled
               n_req      = 1'b1;
               n_state    = fetch_pkg::ACTIVE;
            end
            else if (r_state == fetch_pkg::ACTIVE && r_req && !hit)
            begin
               miss_valid = 1'b1;
               n_miss_pc  = r_cache_pc;
               n_pc       = r_pc;
               n_req      = 1'b0;
               n_state    = fetch_pkg::INJECT_RELOAD;
            end
            else if (r_state == fetch_pkg::ACTIVE && hit && full)
            begin
               n_miss_pc = r_cache_pc;
               n_pc      = r_pc;
               n_req     = 1'b0;
               n_state   = fetch_pkg::WAIT_FOR_NOT_FULL;
            end
            else if (r_state == fetch_pkg::ACTIVE && hit)
            begin
               push         = 1'b1;
               n_delay_slot = t_take;
               if (t_take)
                  n_pc = t_target; // slot is already being read
            end
         end
         fetch_pkg::INJECT_RELOAD:
         begin
            if (fill_valid)
               n_state = fetch_pkg::RELOAD_TURNAROUND;
         end
         fetch_pkg::FLUSH_CACHE:
         begin
            if (flush_done)
            begin
               n_flush_complete = 1'b1;
               n_state          = fetch_pkg::IDLE;
            end
         end
         default:
         begin
            n_state = fetch_pkg::IDLE;
         end
      endcase
      rd_en = n_req;
      rd_pc = n_cache_pc;
   end

   always_ff @(posedge clk)
   begin
      if (restart_valid)
         r_restart_pc <= restart_pc;
      r_miss_pc <= n_miss_pc;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state          <= fetch_pkg::IDLE;
         r_pc             <= '0;
         r_cache_pc       <= '0;
         r_req            <= 1'b0;
         r_delay_slot     <= 1'b0;
         r_restart_req    <= 1'b0;
         r_flush_req      <= 1'b0;
         r_restart_ack    <= 1'b0;
         r_flush_complete <= 1'b0;
      end
      else
      begin
         r_state          <= n_state;
         r_pc             <= n_pc;
         r_cache_pc       <= n_cache_pc;
         r_req            <= n_req;
         r_delay_slot     <= n_delay_slot;
         r_restart_req    <= n_restart_req;
         r_flush_req      <= n_flush_req;
         r_restart_ack    <= n_restart_ack;
         r_flush_complete <= n_flush_complete;
      end
   end

   assign restart_ack    = r_restart_ack;
   assign flush_complete = r_flush_complete;
   assign miss_pc        = r_cache_pc;

endmodule

//--- hdl/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue
#(
   parameter int LG_FQ_ENTRIES = 3
)
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    push,
   input  fetch_pkg::fetch_entry_t push_entry,
   input  logic                    clear,
   output logic                    full,
   output fetch_pkg::fetch_entry_t insn,
   output logic                    insn_valid,
   input  logic                    insn_ack
);

   localparam int N_ENTRIES = 1 << LG_FQ_ENTRIES;

   typedef logic [LG_FQ_ENTRIES:0] fq_ptr_t; // extra wrap bit

   fetch_pkg::fetch_entry_t r_fq [N_ENTRIES];
   fq_ptr_t r_head;
   fq_ptr_t r_tail;

   always_ff @(posedge clk)
   begin
      if (push)
         r_fq[r_tail[LG_FQ_ENTRIES-1:0]] <= push_entry;
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         r_head <= '0;
         r_tail <= '0;
      end
      else
      begin
         if (push)
            r_tail <= r_tail + 1'b1;
         if (insn_ack)
            r_head <= r_head + 1'b1;
      end
   end

   assign insn_valid = (r_head != r_tail);
   assign full       = (r_head[LG_FQ_ENTRIES-1:0] == r_tail[LG_FQ_ENTRIES-1:0]) &&
                       (r_head[LG_FQ_ENTRIES] != r_tail[LG_FQ_ENTRIES]);
   assign insn       = r_fq[r_head[LG_FQ_ENTRIES-1:0]];

endmodule

//--- hdl/l1i_top.sv
`timescale 1ns/1ps

module l1i_top
#(
   parameter int LG_NUM_SETS   = 6,
   parameter int LG_FQ_ENTRIES = 3
)
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    restart_valid,
   input  fetch_pkg::addr_t        restart_pc,
   output logic                    restart_ack,
   input  logic                    flush_req,
   output logic                    flush_complete,
   output fetch_pkg::fetch_entry_t insn,
   output logic                    insn_valid,
   input  logic                    insn_ack,
   output logic                    mem_req_valid,
   output fetch_pkg::addr_t        mem_req_addr,
   input  logic                    mem_rsp_valid,
   input  fetch_pkg::cache_line_t  mem_rsp_load_data
);

   logic                    fill_valid;
   fetch_pkg::addr_t        fill_addr;
   fetch_pkg::cache_line_t  fill_words;
   fetch_pkg::jump_t [fetch_pkg::WORDS_PER_CL-1:0] fill_class;
   logic                    rd_en;
   fetch_pkg::addr_t        rd_pc;
   logic                    hit;
   fetch_pkg::insn_word_t   rd_word;
   fetch_pkg::jump_t        rd_class;
   logic                    miss_valid;
   fetch_pkg::addr_t        miss_pc;
   logic                    flush_start;
   logic                    flush_done;
   logic                    full;
   logic                    push;
   fetch_pkg::fetch_entry_t push_entry;
   logic                    clear;

   icache_refill u_refill
   (
      .clk(clk), .reset(reset),
      .miss_valid(miss_valid), .miss_pc(miss_pc),
      .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
      .mem_rsp_valid(mem_rsp_valid), .mem_rsp_load_data(mem_rsp_load_data),
      .fill_valid(fill_valid), .fill_addr(fill_addr), .fill_words(fill_words)
   );

   // one predecoder per word of the returning line
   for (genvar i = 0; i < fetch_pkg::WORDS_PER_CL; i++)
   begin : g_lane
      insn_predecode u_pd
      (
         .word(fill_words[i]),
         .cls(fill_class[i])
      );
   end

   icache_arrays #(.LG_NUM_SETS(LG_NUM_SETS)) u_arrays
   (
      .clk(clk), .reset(reset),
      .rd_en(rd_en), .rd_pc(rd_pc),
      .hit(hit), .rd_word(rd_word), .rd_class(rd_class),
      .fill_valid(fill_valid), .fill_addr(fill_addr),
      .fill_words(fill_words), .fill_class(fill_class),
      .flush_start(flush_start), .flush_done(flush_done)
   );

   fetch_ctrl u_ctrl
   (
      .clk(clk), .reset(reset),
      .restart_valid(restart_valid), .restart_pc(restart_pc), .restart_ack(restart_ack),
      .flush_req(flush_req), .flush_complete(flush_complete),
      .rd_en(rd_en), .rd_pc(rd_pc),
      .hit(hit), .rd_word(rd_word), .rd_class(rd_class),
      .miss_valid(miss_valid), .miss_pc(miss_pc), .fill_valid(fill_valid),
      .flush_start(flush_start), .flush_done(flush_done),
      .full(full), .push(push), .push_entry(push_entry), .clear(clear)
   );

   fetch_queue #(.LG_FQ_ENTRIES(LG_FQ_ENTRIES)) u_fq
   (
      .clk(clk), .reset(reset),
      .push(push), .push_entry(push_entry), .clear(clear), .full(full),
      .insn(insn), .insn_valid(insn_valid), .insn_ack(insn_ack)
   );

endmodule

//--- dv/l1i_tb.sv
`timescale 1ns/1ps

module l1i_tb;

   localparam fetch_pkg::addr_t BASE   = 32'h0000_1000;
   localparam fetch_pkg::addr_t SEQ_PC = BASE;          // straight-line code
   localparam fetch_pkg::addr_t BR_PC  = BASE + 32'h100; // mixed control flow
   localparam int CYCLES_PER_ENTRY     = 200;

   logic                    clk;
   logic                    reset;
   logic                    restart_valid;
   fetch_pkg::addr_t        restart_pc;
   logic                    restart_ack;
   logic                    flush_req;
   logic                    flush_complete;
   fetch_pkg::fetch_entry_t insn;
   logic                    insn_valid;
   logic                    insn_ack;
   logic                    mem_req_valid;
   fetch_pkg::addr_t        mem_req_addr;
   logic                    mem_rsp_valid;
   fetch_pkg::cache_line_t  mem_rsp_load_data;

   fetch_pkg::insn_word_t   img [fetch_pkg::addr_t]; // keyed by byte address
   fetch_pkg::fetch_entry_t exp_q [$];
   bit                      line_seen [fetch_pkg::addr_t];
   string                   test_name;
   int exp_start     = 0;
   int popped        = 0;
   int cmp_errors    = 0;
   int chk_errors    = 0;
   int req_count     = 0;
   int total_entries = 0;

   l1i_top #(.LG_NUM_SETS(6), .LG_FQ_ENTRIES(3)) u_dut
   (
      .clk(clk), .reset(reset),
      .restart_valid(restart_valid), .restart_pc(restart_pc), .restart_ack(restart_ack),
      .flush_req(flush_req), .flush_complete(flush_complete),
      .insn(insn), .insn_valid(insn_valid), .insn_ack(insn_ack),
      .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
      .mem_rsp_valid(mem_rsp_valid), .mem_rsp_load_data(mem_rsp_load_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic fetch_pkg::insn_word_t alu_word();
      return {6'd9, 26'($urandom)}; // addiu with random fields
   endfunction

   function automatic fetch_pkg::insn_word_t img_word(fetch_pkg::addr_t a);
      if (img.exists(a))
         return img[a];
      return 32'd0; // nop outside the image
   endfunction

   function automatic fetch_pkg::insn_word_t to_big_endian(fetch_pkg::insn_word_t w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   // statically taken per the MIPS encodings
   function automatic bit is_taken(fetch_pkg::insn_word_t w);
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      op = w[31:26];
      rs = w[25:21];
      rt = w[20:16];
      case (op)
         6'd2, 6'd3, 6'd20, 6'd21, 6'd22, 6'd23: return 1'b1;
         6'd4:    return rs == 5'd0 && rt == 5'd0;
         6'd1:    return rt == 5'd2 || rt == 5'd3 || (rt == 5'd17 && rs == 5'd0);
         6'd17:   return rs == 5'd8 && w[17];
         default: return 1'b0;
      endcase
   endfunction

   // forward transfer skipping `skip` words past the delay slot
   function automatic fetch_pkg::insn_word_t make_branch(int kind, fetch_pkg::addr_t pc,
                                                         int skip);
      fetch_pkg::addr_t tgt;
      logic [15:0]      imm;
      logic [4:0]       rs;
      tgt = pc + 8 + 4 * skip;
      imm = 16'(skip + 1);
      rs  = 5'(1 + $urandom % 31);
      case (kind)
         0:       return {6'd2, tgt[27:2]};                     // j
         1:       return {6'd3, tgt[27:2]};                     // jal
         2:       return {6'd4, 5'd0, 5'd0, imm};               // beq r0,r0
         3:       return {6'd20, rs, 5'd0, imm};                // beql
         4:       return {6'd1, 5'd0, 5'd17, imm};              // bal
         5:       return {6'd5, rs, 5'd3, imm};                 // bne
         6:       return {6'd1, rs, 5'd17, imm};                // bgezal
         7:       return {6'd0, rs, 15'd0, 6'd8};               // jr
         8:       return {6'd0, rs, 5'd0, 5'd31, 5'd0, 6'd9};   // jalr
         9:       return {6'd1, rs, 5'd2, imm};                 // bltzl
         10:      return {6'd17, 5'd8, 5'd0, imm};              // bc1f
         default: return {6'd17, 5'd8, 5'd3, imm};              // bc1tl
      endcase
   endfunction

   function automatic void build_image();
      fetch_pkg::addr_t pc;
      int w;
      int skip;
      int kind;
      for (int i = 0; i < 32; i++)
         img[SEQ_PC + 4 * i] = alu_word();
      pc      = SEQ_PC + 128;
      img[pc] = {6'd2, pc[27:2]}; // parks the fetcher
      w    = 64;
      kind = 0;
      while (w < 176)
      begin
         img[BASE + 4 * w] = alu_word();
         skip    = $urandom % 4;
         pc      = BASE + 4 * (w + 1);
         img[pc] = make_branch(kind % 12, pc, skip);
         for (int s = 2; s < 3 + skip; s++)
            img[BASE + 4 * (w + s)] = alu_word(); // delay slot and skipped words
         w = w + 3 + (is_taken(img[pc]) ? skip : 0);
         kind++;
      end
      while (w < 190)
      begin
         img[BASE + 4 * w] = alu_word();
         w++;
      end
      pc      = BASE + 4 * 190;
      img[pc] = {6'd2, pc[27:2]};
   endfunction

   // expected stream up to the second visit of the closing self jump and its line count
   function automatic int build_expected(fetch_pkg::addr_t start);
      fetch_pkg::fetch_entry_t e;
      fetch_pkg::addr_t        pc;
      fetch_pkg::addr_t        tgt;
      fetch_pkg::insn_word_t   w;
      bit                      slot;
      int                      loops;
      exp_q.delete();
      line_seen.delete();
      pc    = start;
      tgt   = '0;
      slot  = 1'b0;
      loops = 0;
      while (loops < 2)
      begin
         w = img_word(pc);
         line_seen[{pc[31:4], 4'h0}] = 1'b1;
         e.data        = w;
         e.pc          = pc;
         e.pred        = 1'b0;
         e.pred_target = pc + 4;
         if (slot)
            e.pred_target = tgt; // slot carries the branch target
         else if (is_taken(w))
         begin
            if (w[31:26] == 6'd2 || w[31:26] == 6'd3)
               tgt = {pc[31:28], w[25:0], 2'b00};
            else
               tgt = pc + 4 + {{14{w[15]}}, w[15:0], 2'b00};
            e.pred        = 1'b1;
            e.pred_target = tgt;
            if (tgt == pc)
               loops++;
         end
         exp_q.push_back(e);
         pc   = slot ? tgt : pc + 4;
         slot = e.pred;
      end
      return line_seen.num();
   endfunction

   task automatic run_stream(input string name, input fetch_pkg::addr_t start, input bit hold,
                             input int exp_reqs);
      int n;
      int issued;
      int stall;
      int err_before;
      int req_before;
      n          = exp_q.size();
      issued     = 0;
      stall      = 0;
      err_before = cmp_errors + chk_errors;
      req_before = req_count;
      test_name  = name;
      exp_start  = popped;
      @(posedge clk);
      #1 restart_valid = 1'b1;
      restart_pc = start;
      @(posedge clk);
      #1 restart_valid = 1'b0;
      while (!restart_ack)
      begin
         @(posedge clk);
         #1;
      end
      while (popped - exp_start < n)
      begin
         if (stall > 0)
            stall--;
         else if (hold && $urandom % 10 == 0)
            stall = 8 + $urandom % 40; // long enough to fill the queue
         insn_ack = insn_valid && issued < n && stall == 0;
         if (insn_ack)
            issued++;
         @(posedge clk);
         #1;
      end
      insn_ack = 1'b0;
      assert (req_count - req_before == exp_reqs)
      else
      begin
         $display("FAIL %s line requests: expected %0d actual %0d", name, exp_reqs,
                  req_count - req_before);
         chk_errors++;
      end
      $display("test %s: %0d entries, %0d line requests, %s", name, n, req_count - req_before,
               (cmp_errors + chk_errors == err_before) ? "ok" : "mismatch");
   endtask

   // line memory with a random answer delay
   initial
   begin : memory_model
      fetch_pkg::addr_t line_addr;
      mem_rsp_valid     = 1'b0;
      mem_rsp_load_data = '0;
      forever
      begin
         @(posedge clk);
         if (mem_req_valid)
         begin
            line_addr = mem_req_addr;
            req_count++;
            assert (line_seen.exists(line_addr))
            else
            begin
               $display("%s: memory request for line %h outside the fetched code",
                        test_name, line_addr);
               chk_errors++;
            end
            repeat (2 + $urandom % 5) @(posedge clk);
            #1 mem_rsp_load_data = {to_big_endian(img_word(line_addr + 12)),
                                    to_big_endian(img_word(line_addr + 8)),
                                    to_big_endian(img_word(line_addr + 4)),
                                    to_big_endian(img_word(line_addr))};
            mem_rsp_valid = 1'b1;
            @(posedge clk);
            #1 mem_rsp_valid = 1'b0;
         end
      end
   end

   always @(posedge clk)
   begin : compare
      int idx;
      if (!reset && insn_valid && insn_ack)
      begin
         idx = popped - exp_start;
         assert (insn == exp_q[idx])
         else
         begin
            $display("FAIL %s entry %0d: expected %h actual %h", test_name, idx,
                     exp_q[idx], insn);
            cmp_errors++;
         end
         popped++;
      end
   end

   initial
   begin : watchdog
      wait (total_entries > 0);
      repeat (total_entries * CYCLES_PER_ENTRY + 5000) @(posedge clk);
      $display("watchdog: the tests did not finish in the allowed time");
      $display("Verification failed");
      $finish;
   end

   initial
   begin : stimulus
      int seq_lines;
      int br_lines;
      int br_entries;
      reset         = 1'b1;
      restart_valid = 1'b0;
      restart_pc    = '0;
      flush_req     = 1'b0;
      insn_ack      = 1'b0;
      test_name     = "reset";
      void'($urandom(32'hcac5e1cb));
      build_image();
      br_lines      = build_expected(BR_PC);
      br_entries    = exp_q.size();
      seq_lines     = build_expected(SEQ_PC);
      total_entries = exp_q.size() + 4 * br_entries;
      repeat (4) @(posedge clk);
      #1 reset = 1'b0;
      assert (!insn_valid && !mem_req_valid && !restart_ack && !flush_complete)
      else
      begin
         $display("outputs are not low after reset");
         chk_errors++;
      end
      run_stream("sequential", SEQ_PC, 1'b0, seq_lines);
      void'(build_expected(BR_PC));
      run_stream("cflow", BR_PC, 1'b0, br_lines);
      run_stream("rehit", BR_PC, 1'b0, 0); // all lines already cached
      run_stream("backpressure", BR_PC, 1'b1, 0);
      @(posedge clk);
      #1 flush_req = 1'b1;
      @(posedge clk);
      #1 flush_req = 1'b0;
      while (!flush_complete)
      begin
         @(posedge clk);
         #1;
      end
      run_stream("flush", BR_PC, 1'b0, br_lines);
      $display("tests done: %0d entries checked, %0d errors", popped,
               cmp_errors + chk_errors);
      if (cmp_errors + chk_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- all.f
hdl/fetch_pkg.sv
hdl/icache_refill.sv
hdl/insn_predecode.sv
hdl/icache_arrays.sv
hdl/fetch_ctrl.sv
hdl/fetch_queue.sv
hdl/l1i_top.sv
dv/l1i_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module l1i_tb -f all.f -o l1i_sim &&
./obj_dir/l1i_sim | grep "Verification passed" && exit 0 ||
{ echo "simulation did not pass"; exit 1; }
